/* rvPkg.sv */
package rvPkg;

    localparam int xlen     = 32;
    localparam int regCount = 8;
    localparam int regIdxW  = $clog2(regCount); // only low bits of rs/rd used
    localparam int memWords = 64;
    localparam int memIdxW  = $clog2(memWords);

    typedef enum logic [6:0] {
        lui    = 7'b0110111,
        jal    = 7'b1101111,
        jalr   = 7'b1100111,
        load   = 7'b0000011,
        store  = 7'b0100011,
        branch = 7'b1100011,
        opImm  = 7'b0010011,
        opReg  = 7'b0110011
    } opcodeE;

    typedef enum logic [1:0] {
        add   = 2'b00,
        sub   = 2'b01,
        funct = 2'b10, // look at funct3/funct7
        passB = 2'b11
    } aluClassE;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluPassB
    } aluOpE;

    typedef enum logic [2:0] {
        immI,
        immS,
        immB,
        immU,
        immJ
    } immKindE;

    typedef struct packed {
        logic     regWrite;
        immKindE  immKind;
        logic     aluSrc;    // 1 selects imm as ALU operand b
        logic     memWrite;
        logic     resultSrc; // 1 selects load data
        logic     pcSrc;
        aluClassE aluClass;
        logic     jalrSrc;   // target from ALU instead of pc+imm
        logic     jumpSrc;   // write back pc+4
    } ctrlT;

    // one record per retired instruction
    typedef struct packed {
        logic            regWrite;
        logic [4:0]      rd;
        logic [xlen-1:0] result;
        logic            memWrite;
        logic [xlen-1:0] memAddr;
        logic [xlen-1:0] memData;
    } retireT;

endpackage

/* mainDecoder.sv */
module mainDecoder import rvPkg::*; (
    input  logic [6:0] op,
    input  logic       zero,
    output ctrlT       ctrl
);

    always_comb begin
        case (opcodeE'(op))
            jal: begin
                ctrl.regWrite  = 1'b1; // rd = pc+4
                ctrl.immKind   = immJ;
                ctrl.aluSrc    = 1'b1;
                ctrl.memWrite  = 1'b0;
                ctrl.resultSrc = 1'b0;
                ctrl.pcSrc     = 1'b1;
                ctrl.aluClass  = add;
                ctrl.jalrSrc   = 1'b0;
                ctrl.jumpSrc   = 1'b1;
            end
            jalr: begin
                ctrl.regWrite  = 1'b1;
                ctrl.immKind   = immI;
                ctrl.aluSrc    = 1'b1; // rs1 + imm
                ctrl.memWrite  = 1'b0;
                ctrl.resultSrc = 1'b0;
                ctrl.pcSrc     = 1'b1;
                ctrl.aluClass  = add;
                ctrl.jalrSrc   = 1'b1;
                ctrl.jumpSrc   = 1'b1;
            end
            load: begin
                ctrl.regWrite  = 1'b1;
                ctrl.immKind   = immI;
                ctrl.aluSrc    = 1'b1;
                ctrl.memWrite  = 1'b0;
                ctrl.resultSrc = 1'b1;
                ctrl.pcSrc     = 1'b0;
                ctrl.aluClass  = add;
                ctrl.jalrSrc   = 1'b0;
                ctrl.jumpSrc   = 1'b0;
            end
            store: begin
                ctrl.regWrite  = 1'b0;
                ctrl.immKind   = immS;
                ctrl.aluSrc    = 1'b1;
                ctrl.memWrite  = 1'b1;
                ctrl.resultSrc = 1'b0;
                ctrl.pcSrc     = 1'b0;
                ctrl.aluClass  = add;
                ctrl.jalrSrc   = 1'b0;
                ctrl.jumpSrc   = 1'b0;
            end
            lui: begin
                ctrl.regWrite  = 1'b1;
                ctrl.immKind   = immU;
                ctrl.aluSrc    = 1'b1;
                ctrl.memWrite  = 1'b0;
                ctrl.resultSrc = 1'b0;
                ctrl.pcSrc     = 1'b0;
                ctrl.aluClass  = passB; // ALU forwards the immediate
                ctrl.jalrSrc   = 1'b0;
                ctrl.jumpSrc   = 1'b0;
            end
            opImm: begin
                ctrl.regWrite  = 1'b1;
                ctrl.immKind   = immI;
                ctrl.aluSrc    = 1'b1;
                ctrl.memWrite  = 1'b0;
                ctrl.resultSrc = 1'b0;
                ctrl.pcSrc     = 1'b0;
                ctrl.aluClass  = funct;
                ctrl.jalrSrc   = 1'b0;
                ctrl.jumpSrc   = 1'b0;
            end
            opReg: begin
                ctrl.regWrite  = 1'b1;
                ctrl.immKind   = immI; // unused
                ctrl.aluSrc    = 1'b0;
                ctrl.memWrite  = 1'b0;
                ctrl.resultSrc = 1'b0;
                ctrl.pcSrc     = 1'b0;
                ctrl.aluClass  = funct;
                ctrl.jalrSrc   = 1'b0;
                ctrl.jumpSrc   = 1'b0;
            end
            branch: begin
                ctrl.regWrite  = 1'b0;
                ctrl.immKind   = immB;
                ctrl.aluSrc    = 1'b0;
                ctrl.memWrite  = 1'b0;
                ctrl.resultSrc = 1'b0;
                ctrl.pcSrc     = zero; // beq taken on equal operands
                ctrl.aluClass  = sub;
                ctrl.jalrSrc   = 1'b0;
                ctrl.jumpSrc   = 1'b0;
            end
            default: begin
                // unknown opcode retires as a no-op
                ctrl = '0;
            end
        endcase
    end

endmodule

/* aluDecoder.sv */
module aluDecoder import rvPkg::*; (
    input  aluClassE   aluClass,
    input  logic [2:0] funct3,
    input  logic       funct7b5,
    input  logic       opB5,
    output aluOpE      aluOp
);

    logic isSub;

    assign isSub = funct7b5 & opB5; // R-type sub only, never addi

    always_comb begin
        case (aluClass)
            add:   aluOp = aluAdd;
            sub:   aluOp = aluSub;
            passB: aluOp = aluPassB;
            funct: begin
                case (funct3)
                    3'b000:  aluOp = isSub ? aluSub : aluAdd;
                    3'b010:  aluOp = aluSlt;
                    3'b100:  aluOp = aluXor;
                    3'b110:  aluOp = aluOr;
                    3'b111:  aluOp = aluAnd;
                    default: aluOp = aluAdd; // shifts not supported
                endcase
            end
            default: aluOp = aluAdd;
        endcase
    end

endmodule

/* alu.sv */
module alu import rvPkg::*; (
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    input  aluOpE           aluOp,
    output logic [xlen-1:0] result,
    output logic            zero
);

    logic lessThan;

    assign lessThan = $signed(a) < $signed(b);

    always_comb begin
        case (aluOp)
            aluAdd:   result = a + b;
            aluSub:   result = a - b;
            aluAnd:   result = a & b;
            aluOr:    result = a | b;
            aluXor:   result = a ^ b;
            aluSlt:   result = {{(xlen-1){1'b0}}, lessThan};
            aluPassB: result = b; // lui
            default:  result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

/* regFile.sv */
module regFile import rvPkg::*; (
    input  logic               clk,
    input  logic               rstN,
    input  logic               we,
    input  logic [regIdxW-1:0] ra1,
    input  logic [regIdxW-1:0] ra2,
    input  logic [regIdxW-1:0] wa,
    input  logic [xlen-1:0]    wd,
    output logic [xlen-1:0]    rd1,
    output logic [xlen-1:0]    rd2
);

    logic [xlen-1:0] regs [regCount];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != '0) begin // x0 stays zero
            regs[wa] <= wd;
        end
    end

    assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

/* immExtend.sv */
module immExtend import rvPkg::*; (
    input  logic [xlen-1:0] instr,
    input  immKindE         immKind,
    output logic [xlen-1:0] imm
);

    always_comb begin
        case (immKind)
            immI: imm = {{20{instr[31]}}, instr[31:20]};
            immS: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            immB: imm = {{19{instr[31]}}, instr[31], instr[7],
                         instr[30:25], instr[11:8], 1'b0};
            immU: imm = {instr[31:12], 12'b0};
            immJ: imm = {{11{instr[31]}}, instr[31], instr[19:12],
                         instr[20], instr[30:21], 1'b0}; // own format, not lui's
            default: imm = '0;
        endcase
    end

endmodule

/* dataMemory.sv */
module dataMemory import rvPkg::*; (
    input  logic            clk,
    input  logic            rstN,
    input  logic            we,
    input  logic [xlen-1:0] addr,
    input  logic [xlen-1:0] wd,
    output logic [xlen-1:0] rd
);

    logic [xlen-1:0]    mem [memWords];
    logic [memIdxW-1:0] wordIdx;

    assign wordIdx = addr[memIdxW+1:2]; // word aligned, upper bits ignored

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < memWords; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[wordIdx] <= wd;
        end
    end

    assign rd = mem[wordIdx];

endmodule

/* riscvTop.sv */
module riscvTop import rvPkg::*; (
    input  logic            clk,
    input  logic            rstN,
    input  logic [xlen-1:0] instr,
    output logic [xlen-1:0] pc,
    output retireT          retire
);

    ctrlT            ctrl;
    aluOpE           aluOp;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] rd1;
    logic [xlen-1:0] rd2;
    logic [xlen-1:0] srcB;
    logic [xlen-1:0] aluResult;
    logic            zero;
    logic [xlen-1:0] readData;
    logic [xlen-1:0] pcPlus4;
    logic [xlen-1:0] pcTarget;
    logic [xlen-1:0] pcNext;
    logic [xlen-1:0] wbData;

    mainDecoder decoder_i (
        .op   (instr[6:0]),
        .zero (zero),
        .ctrl (ctrl)
    );

    aluDecoder aluDecoder_i (
        .aluClass (ctrl.aluClass),
        .funct3   (instr[14:12]),
        .funct7b5 (instr[30]),
        .opB5     (instr[5]),
        .aluOp    (aluOp)
    );

    regFile regFile_i (
        .clk  (clk),
        .rstN (rstN),
        .we   (ctrl.regWrite),
        .ra1  (instr[15 +: regIdxW]), // low bits of rs1
        .ra2  (instr[20 +: regIdxW]),
        .wa   (instr[7 +: regIdxW]),
        .wd   (wbData),
        .rd1  (rd1),
        .rd2  (rd2)
    );

    immExtend immExtend_i (
        .instr   (instr),
        .immKind (ctrl.immKind),
        .imm     (imm)
    );

    assign srcB = ctrl.aluSrc ? imm : rd2;

    alu alu_i (
        .a      (rd1),
        .b      (srcB),
        .aluOp  (aluOp),
        .result (aluResult),
        .zero   (zero)
    );

    dataMemory dataMemory_i (
        .clk  (clk),
        .rstN (rstN),
        .we   (ctrl.memWrite),
        .addr (aluResult),
        .wd   (rd2),
        .rd   (readData)
    );

    assign pcPlus4  = pc + 32'd4;
    assign pcTarget = pc + imm; // branch and jal
    assign pcNext   = !ctrl.pcSrc  ? pcPlus4 :
                      ctrl.jalrSrc ? {aluResult[xlen-1:2], 2'b00} : pcTarget;

    assign wbData = ctrl.jumpSrc   ? pcPlus4  :
                    ctrl.resultSrc ? readData : aluResult;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

    // fields that do not apply to this instruction report zero
    assign retire.regWrite = ctrl.regWrite;
    assign retire.rd       = instr[11:7];
    assign retire.result   = ctrl.regWrite ? wbData : '0;
    assign retire.memWrite = ctrl.memWrite;
    assign retire.memAddr  = ctrl.memWrite ? aluResult : '0;
    assign retire.memData  = ctrl.memWrite ? rd2 : '0;

endmodule

/* riscvTop_asserts.sv */
module riscvTopAsserts import rvPkg::*; (
    input logic            clk,
    input logic            rstN,
    input logic [xlen-1:0] pc,
    input retireT          retire
);

    pcAligned: assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00)
        else $error("pc %h is not word aligned", pc);

    oneWriteKind: assert property (@(posedge clk) disable iff (!rstN)
        !(retire.memWrite && retire.regWrite))
        else $error("register and memory write in the same instruction");

    pcZeroAfterReset: assert property (@(posedge clk) !rstN |=> pc == '0)
        else $error("pc %h is not zero after reset", pc);

endmodule

bind riscvTop riscvTopAsserts asserts_i (.clk(clk), .rstN(rstN), .pc(pc), .retire(retire));

/* riscvChecker.sv */
module riscvChecker import rvPkg::*; (
    input  logic            clk,
    input  logic            rstN,
    input  logic [xlen-1:0] instr,
    input  logic [xlen-1:0] pc,
    input  retireT          retire,
    output int              errors,
    output int              retired
);

    logic [xlen-1:0] regs [regCount];
    logic [xlen-1:0] mem [memWords];
    logic [xlen-1:0] modelPc;
    int              errCount = 0;
    int              retCount = 0;

    assign errors  = errCount;
    assign retired = retCount;

    function automatic logic [xlen-1:0] aluModel(input logic [2:0] f3, input logic [xlen-1:0] x,
                                                 input logic [xlen-1:0] y, input logic useSub);
        case (f3)
            3'b000:  return useSub ? x - y : x + y;
            3'b010:  return {31'b0, $signed(x) < $signed(y)};
            3'b100:  return x ^ y;
            3'b110:  return x | y;
            default: return x & y;
        endcase
    endfunction

    task automatic compare(input string name, input logic [xlen-1:0] exp,
                           input logic [xlen-1:0] act);
        if (act !== exp) begin
            $display("** Error: %s expected %h got %h, model pc %h", name, exp, act, modelPc);
            errCount++;
        end
    endtask

    always @(posedge clk) begin
        logic [xlen-1:0] a, b, iImm, sImm, bImm, jImm, addr, res, nextPc;
        logic            wr, mw;
        if (!rstN) begin
            modelPc = '0;
            for (int i = 0; i < memWords; i++) begin
                mem[i] = '0;
                if (i < regCount) regs[i] = '0;
            end
        end else begin
            a      = regs[instr[17:15]];
            b      = regs[instr[22:20]];
            iImm   = {{20{instr[31]}}, instr[31:20]};
            sImm   = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            bImm   = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            jImm   = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            addr   = a + (instr[5] ? sImm : iImm); // store vs load offset
            wr     = 1'b0;
            mw     = 1'b0;
            res    = '0;
            nextPc = modelPc + 32'd4;
            case (instr[6:0])
                7'b0110111: {wr, res} = {1'b1, instr[31:12], 12'b0};
                7'b1101111: {wr, res, nextPc} = {1'b1, modelPc + 32'd4, modelPc + jImm};
                7'b1100111: {wr, res, nextPc} = {1'b1, modelPc + 32'd4, (a + iImm) & ~32'd3};
                7'b0000011: {wr, res} = {1'b1, mem[addr[7:2]]};
                7'b0100011: mw = 1'b1;
                7'b1100011: nextPc = (a == b) ? modelPc + bImm : nextPc;
                7'b0010011: {wr, res} = {1'b1, aluModel(instr[14:12], a, iImm, 1'b0)};
                7'b0110011: {wr, res} = {1'b1, aluModel(instr[14:12], a, b, instr[30])};
                default:    wr = 1'b0; // no-op
            endcase
            compare("pc", modelPc, pc);
            compare("retire.regWrite", {31'b0, wr}, {31'b0, retire.regWrite});
            if (wr) compare("retire.rd", {27'b0, instr[11:7]}, {27'b0, retire.rd});
            compare("retire.result", wr ? res : '0, retire.result);
            compare("retire.memWrite", {31'b0, mw}, {31'b0, retire.memWrite});
            compare("retire.memAddr", mw ? addr : '0, retire.memAddr);
            compare("retire.memData", mw ? b : '0, retire.memData);
            retCount++;
            if (wr && instr[9:7] != 3'd0) regs[instr[9:7]] = res;
            if (mw) mem[addr[7:2]] = b;
            modelPc = nextPc;
        end
    end

endmodule

/* riscvTb.sv */
module riscvTb import rvPkg::*; ();

    logic            clk;
    logic            rstN;
    logic [xlen-1:0] instr;
    logic [xlen-1:0] pc;
    retireT          retire;
    logic [31:0]     lfsr;
    logic            timedOut;
    int              errors;
    int              retired;
    int              driven;
    int              errorsSeen;
    int              testsRun;
    int              testsFailed;

    riscvTop dut_i (.clk(clk), .rstN(rstN), .instr(instr), .pc(pc), .retire(retire));

    riscvChecker checker_i (
        .clk(clk), .rstN(rstN), .instr(instr), .pc(pc), .retire(retire),
        .errors(errors), .retired(retired)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic takeBits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1; // galois step
            v = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic buildInstr(output logic [31:0] w);
        logic [31:0] ctl;
        logic [31:0] r;
        logic [31:0] imm;
        logic [2:0]  rd, rs1, rs2, base, f3;
        takeBits(16, ctl);
        takeBits(20, r);
        rd   = ctl[11:9];
        rs1  = ctl[8:6];
        rs2  = r[8] ? rs1 : ctl[5:3]; // equal operands for beq now and then
        base = r[6] ? rs1 : 3'd0;
        imm  = {{24{r[5]}}, r[5:0], 2'b00}; // word multiples
        case (ctl[2:0])
            3'd0, 3'd1: f3 = 3'b000;
            3'd2, 3'd3: f3 = 3'b010;
            3'd4:       f3 = 3'b100;
            3'd5:       f3 = 3'b110;
            default:    f3 = 3'b111;
        endcase
        case (ctl[15:12])
            4'd0, 4'd1, 4'd2, 4'd3: w = {1'b0, r[7] && f3 == 3'b000, 5'b0, 2'b0, rs2,
                                         2'b0, rs1, f3, 2'b0, rd, 7'b0110011};
            4'd4, 4'd5, 4'd6: w = {r[11:0], 2'b0, rs1, f3, 2'b0, rd, 7'b0010011};
            4'd7:             w = {r[19:0], 2'b0, rd, 7'b0110111};
            4'd8, 4'd9:       w = {imm[11:5], 2'b0, rs2, 2'b0, base, 3'b010, imm[4:0], 7'b0100011};
            4'd10, 4'd11:     w = {imm[11:0], 2'b0, base, 3'b010, 2'b0, rd, 7'b0000011};
            4'd12, 4'd13:     w = {imm[12], imm[10:5], 2'b0, rs2, 2'b0, rs1, 3'b000,
                                   imm[4:1], imm[11], 7'b1100011};
            4'd14:            w = {imm[20], imm[10:1], imm[11], imm[19:12], 2'b0, rd, 7'b1101111};
            default:          w = {r[11:0], 2'b0, rs1, 3'b000, 2'b0, rd, 7'b1100111};
        endcase
    endtask

    task automatic applyReset();
        rstN  <= 1'b0;
        instr <= '0;
        repeat (2) @(posedge clk);
        rstN  <= 1'b1;
    endtask

    task automatic runRandom(input int n);
        logic [31:0] w;
        for (int i = 0; i < n; i++) begin
            buildInstr(w);
            instr <= w;
            driven++;
            @(posedge clk);
        end
    endtask

    // add xi, xi, x(7-i) then lw xi, 36*i(x0)
    task automatic runResetReads();
        for (int i = 0; i < 8; i++) begin
            instr <= {7'b0, 2'b0, 3'(7 - i), 2'b0, 3'(i), 3'b000, 2'b0, 3'(i), 7'b0110011};
            @(posedge clk);
            instr <= {12'(36 * i), 5'b0, 3'b010, 2'b0, 3'(i), 7'b0000011};
            @(posedge clk);
            driven += 2;
        end
    endtask

    task automatic endTest(input string name);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (retired < driven && cycles < 20) begin
            @(negedge clk);
            cycles++;
        end
        testsRun++;
        if (retired < driven) begin
            $display("test %0d %s: timed out with %0d of %0d instructions retired",
                     testsRun, name, retired, driven);
            timedOut = 1'b1;
            testsFailed++;
        end else if (errors != errorsSeen) begin
            $display("test %0d %s: failed, %0d errors", testsRun, name, errors - errorsSeen);
            testsFailed++;
        end else begin
            $display("test %0d %s: ok", testsRun, name);
        end
        errorsSeen = errors;
    endtask

    initial begin
        rstN        = 1'b0;
        instr       = '0;
        lfsr        = 32'd92;
        timedOut    = 1'b0;
        driven      = 0;
        errorsSeen  = 0;
        testsRun    = 0;
        testsFailed = 0;
        applyReset();
        runRandom(200);
        endTest("random mix");
        if (!timedOut) begin
            @(posedge clk);
            applyReset(); // second reset mid run
            runResetReads();
            endTest("reads after reset");
        end
        if (!timedOut) begin
            @(posedge clk);
            runRandom(184);
            endTest("random after reset");
        end
        $display("%0d tests, %0d failed, %0d instructions checked, %0d errors",
                 testsRun, testsFailed, retired, errors);
        if (testsFailed == 0 && errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* sim.f */
rvPkg.sv
mainDecoder.sv
aluDecoder.sv
alu.sv
regFile.sv
immExtend.sv
dataMemory.sv
riscvTop.sv
riscvTop_asserts.sv
riscvChecker.sv
riscvTb.sv

/* run.sh */
#!/usr/bin/env bash
set -eo pipefail
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module riscvTb -f sim.f -o riscvSim
./obj_dir/riscvSim | tee sim.log
if grep -q "FAIL: see errors above" sim.log; then
    exit 1
fi
